// ==== source/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int APB_ADDR_W = 8;

    // apb write offset for instruction words
    localparam logic [APB_ADDR_W-1:0] INSTR_OFFSET = 8'h00;

    // major opcodes of the kept groups
    localparam logic [6:0] OPCODE_OP     = 7'b0110011;
    localparam logic [6:0] OPCODE_OP_IMM = 7'b0010011;

    // funct3 codes
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7, alt selects sub and sra
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // alu writes rd, read returns rs1 to the host
    typedef enum logic {
        UOP_ALU,
        UOP_READ
    } uop_kind_t;

    typedef struct packed {
        uop_kind_t             kind;
        alu_op_t               alu_op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
    } uop_t;

endpackage

`default_nettype wire

// ==== source/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
    input  rv_pkg::alu_op_t         i_op,
    input  logic [rv_pkg::XLEN-1:0] i_a,
    input  logic [rv_pkg::XLEN-1:0] i_b,
    output logic [rv_pkg::XLEN-1:0] o_y
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // shifts take only the low five bits
    assign shamt       = i_b[4:0];
    assign lt_signed   = ($signed(i_a) < $signed(i_b));
    assign lt_unsigned = (i_a < i_b);

    always_comb
    begin
        case (i_op)
            ALU_ADD:  o_y = i_a + i_b;
            ALU_SUB:  o_y = i_a - i_b;
            ALU_SLL:  o_y = i_a << shamt;
            // set-less-than, result is 0 or 1
            ALU_SLT:  o_y = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: o_y = {{(XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:  o_y = i_a ^ i_b;
            ALU_SRL:  o_y = i_a >> shamt;
            // arithmetic shift keeps the sign
            ALU_SRA:  o_y = $unsigned($signed(i_a) >>> shamt);
            ALU_OR:   o_y = i_a | i_b;
            ALU_AND:  o_y = i_a & i_b;
            default:  o_y = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rs2,
    input  logic                          i_we,
    input  logic [rv_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic [rv_pkg::XLEN-1:0]       i_wdata,
    output logic [rv_pkg::XLEN-1:0]       o_rs1_data,
    output logic [rv_pkg::XLEN-1:0]       o_rs2_data
);
    import rv_pkg::*;

    // x1..x31, x0 has no storage
    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_we && i_rd != '0)
        begin
            regs[i_rd] <= i_wdata;
        end
    end

    // no bypass here, execute forwards
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

// ==== source/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    i_uop_valid,
    input  rv_pkg::uop_t            i_uop,
    output logic                    o_uop_ready,
    output logic                    o_rd_valid,
    output logic [rv_pkg::XLEN-1:0] o_rd_data
);
    import rv_pkg::*;

    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       op_a;
    logic [XLEN-1:0]       op_b;
    logic [XLEN-1:0]       alu_y;
    logic                  fwd_a;
    logic                  fwd_b;
    logic                  wb_writes;

    // writeback register
    logic                  wb_valid;
    uop_kind_t             wb_kind;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    // single stage, never stalls
    assign o_uop_ready = 1'b1;

    rv_regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_rs1      (i_uop.rs1),
        .i_rs2      (i_uop.rs2),
        .i_we       (wb_writes),
        .i_rd       (wb_rd),
        .i_wdata    (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    //////////////////////////////////////////////////
    // operand fetch with writeback forwarding
    //////////////////////////////////////////////////
    // only alu results to a real register count
    assign wb_writes = wb_valid && (wb_kind == UOP_ALU) && (wb_rd != '0);
    assign fwd_a     = wb_writes && (wb_rd == i_uop.rs1);
    assign fwd_b     = wb_writes && (wb_rd == i_uop.rs2);

    assign op_a = fwd_a ? wb_data : rs1_data;
    // immediate replaces rs2 for OP_IMM
    assign op_b = i_uop.use_imm ? i_uop.imm : (fwd_b ? wb_data : rs2_data);

    rv_alu u_alu (
        .i_op (i_uop.alu_op),
        .i_a  (op_a),
        .i_b  (op_b),
        .o_y  (alu_y)
    );

    //////////////////////////////////////////////////
    // stage register
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= i_uop_valid & o_uop_ready;
    end

    always_ff @(posedge clk)
    begin
        if (i_uop_valid)
        begin
            wb_kind <= i_uop.kind;
            wb_rd   <= i_uop.rd;
            // read micro-op carries the forwarded rs1
            wb_data <= (i_uop.kind == UOP_READ) ? op_a : alu_y;
        end
    end

    // one-cycle pulse back to the decoder
    assign o_rd_valid = wb_valid && (wb_kind == UOP_READ);
    assign o_rd_data  = wb_data;

endmodule

`default_nettype wire

// ==== source/uop_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module uop_fifo #(
    parameter int  FIFO_DEPTH = 4,
    parameter type payload_t  = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     i_push_valid,
    input  payload_t i_push_data,
    output logic     o_push_ready,
    output logic     o_pop_valid,
    output payload_t o_pop_data,
    input  logic     i_pop_ready
);
    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    payload_t   mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // full blocks push, empty hides pop
    assign o_push_ready = (count != CNT_W'(FIFO_DEPTH));
    assign o_pop_valid  = (count != '0);
    assign push         = i_push_valid & o_push_ready;
    assign pop          = o_pop_valid & i_pop_ready;

    // registered head, no fall-through
    assign o_pop_data = mem[rd_ptr];

    ////////////////////////////////////////////////////
    // pointers and occupancy
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // simultaneous push and pop keep the count
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // storage
    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= i_push_data;
    end

endmodule

`default_nettype wire

// ==== source/rv_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_psel,
    input  logic                          i_penable,
    input  logic                          i_pwrite,
    input  logic [rv_pkg::APB_ADDR_W-1:0] i_paddr,
    input  logic [rv_pkg::XLEN-1:0]       i_pwdata,
    output logic [rv_pkg::XLEN-1:0]       o_prdata,
    output logic                          o_pready,
    output logic                          o_pslverr,
    input  logic                          i_push_ready,
    output logic                          o_push_valid,
    output rv_pkg::uop_t                  o_push_uop,
    input  logic                          i_rd_valid,
    input  logic [rv_pkg::XLEN-1:0]       i_rd_data
);
    import rv_pkg::*;

    // idle, read pushed and waiting, read data ready
    typedef enum logic [1:0] {ST_IDLE, ST_WAIT, ST_DONE} state_t;

    state_t          state_q;
    state_t          state_d;
    logic [XLEN-1:0] rdata_q;
    logic            access;
    logic            rd_addr_ok;
    logic            instr_ok;
    logic [6:0]      opcode;
    logic [6:0]      funct7;
    logic [2:0]      funct3;
    uop_t            alu_uop;

    assign access = i_psel & i_penable;
    assign opcode = i_pwdata[6:0];
    assign funct3 = i_pwdata[14:12];
    assign funct7 = i_pwdata[31:25];

    // word aligned and inside x0..x31
    assign rd_addr_ok = (i_paddr[1:0] == 2'b00)
                      && (i_paddr[APB_ADDR_W-1:REG_ADDR_W+2] == '0);

    //////////////////////////////////////////////////
    // instruction decode
    //////////////////////////////////////////////////
    always_comb
    begin
        alu_uop         = '0;
        alu_uop.kind    = UOP_ALU;
        alu_uop.rd      = i_pwdata[11:7];
        alu_uop.rs1     = i_pwdata[19:15];
        alu_uop.rs2     = i_pwdata[24:20];
        alu_uop.use_imm = (opcode == OPCODE_OP_IMM);
        // i-immediate, sign extended
        alu_uop.imm     = {{(XLEN-12){i_pwdata[31]}}, i_pwdata[31:20]};
        case (funct3)
            // no subi, funct7 only matters for OP
            F3_ADD_SUB: alu_uop.alu_op = (opcode == OPCODE_OP && funct7 == F7_ALT) ? ALU_SUB
                                                                                      : ALU_ADD;
            F3_SLL:     alu_uop.alu_op = ALU_SLL;
            F3_SLT:     alu_uop.alu_op = ALU_SLT;
            F3_SLTU:    alu_uop.alu_op = ALU_SLTU;
            F3_XOR:     alu_uop.alu_op = ALU_XOR;
            // srai keeps its alt bit in imm[10]
            F3_SRL_SRA: alu_uop.alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_uop.alu_op = ALU_OR;
            default:    alu_uop.alu_op = ALU_AND;
        endcase

        // legal encodings only
        if (opcode == OPCODE_OP)
        begin
            instr_ok = (funct7 == F7_BASE)
                     || (funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));
        end
        else if (opcode == OPCODE_OP_IMM)
        begin
            if (funct3 == F3_SLL)
                instr_ok = (funct7 == F7_BASE);
            else if (funct3 == F3_SRL_SRA)
                instr_ok = (funct7 == F7_BASE) || (funct7 == F7_ALT);
            else
                instr_ok = 1'b1;
        end
        else
        begin
            instr_ok = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // apb access control
    //////////////////////////////////////////////////
    always_comb
    begin
        state_d      = state_q;
        o_push_valid = 1'b0;
        o_push_uop   = alu_uop;
        o_pready     = 1'b0;
        o_pslverr    = 1'b0;
        case (state_q)
            ST_IDLE:
            begin
                if (access && i_pwrite)
                begin
                    if (i_paddr != INSTR_OFFSET || !instr_ok)
                    begin
                        // error completes at once, nothing pushed
                        o_pready  = 1'b1;
                        o_pslverr = 1'b1;
                    end
                    else
                    begin
                        // wait states while fifo full
                        o_push_valid = 1'b1;
                        o_pready     = i_push_ready;
                    end
                end
                else if (access)
                begin
                    if (!rd_addr_ok)
                    begin
                        o_pready  = 1'b1;
                        o_pslverr = 1'b1;
                    end
                    else
                    begin
                        // register read travels as a micro-op
                        o_push_valid   = 1'b1;
                        o_push_uop     = '0;
                        o_push_uop.kind = UOP_READ;
                        o_push_uop.rs1 = i_paddr[2 +: REG_ADDR_W];
                        if (i_push_ready)
                            state_d = ST_WAIT;
                    end
                end
            end
            ST_WAIT:
            begin
                if (i_rd_valid)
                    state_d = ST_DONE;
            end
            ST_DONE:
            begin
                o_pready = 1'b1;
                state_d  = ST_IDLE;
            end
            default:
            begin
                state_d = ST_IDLE;
            end
        endcase
    end

    assign o_prdata = (state_q == ST_DONE) ? rdata_q : '0;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state_q <= ST_IDLE;
        else
            state_q <= state_d;
    end

    // read return capture
    always_ff @(posedge clk)
    begin
        if (state_q == ST_WAIT && i_rd_valid)
            rdata_q <= i_rd_data;
    end

endmodule

`default_nettype wire

// ==== source/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_psel,
    input  logic                          i_penable,
    input  logic                          i_pwrite,
    input  logic [rv_pkg::APB_ADDR_W-1:0] i_paddr,
    input  logic [rv_pkg::XLEN-1:0]       i_pwdata,
    output logic [rv_pkg::XLEN-1:0]       o_prdata,
    output logic                          o_pready,
    output logic                          o_pslverr
);
    import rv_pkg::*;

    // decode to fifo
    logic            push_valid;
    logic            push_ready;
    uop_t            push_uop;
    // fifo to execute
    logic            pop_valid;
    logic            pop_ready;
    uop_t            pop_uop;
    // read return
    logic            rd_valid;
    logic [XLEN-1:0] rd_data;

    //////////////////////////////////////////////////
    // apb slave and decode
    rv_decoder u_decoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_psel       (i_psel),
        .i_penable    (i_penable),
        .i_pwrite     (i_pwrite),
        .i_paddr      (i_paddr),
        .i_pwdata     (i_pwdata),
        .o_prdata     (o_prdata),
        .o_pready     (o_pready),
        .o_pslverr    (o_pslverr),
        .i_push_ready (push_ready),
        .o_push_valid (push_valid),
        .o_push_uop   (push_uop),
        .i_rd_valid   (rd_valid),
        .i_rd_data    (rd_data)
    );

    // micro-op buffer
    uop_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .payload_t  (uop_t)
    ) u_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_push_valid (push_valid),
        .i_push_data  (push_uop),
        .o_push_ready (push_ready),
        .o_pop_valid  (pop_valid),
        .o_pop_data   (pop_uop),
        .i_pop_ready  (pop_ready)
    );

    rv_execute u_execute (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_uop_valid (pop_valid),
        .i_uop       (pop_uop),
        .o_uop_ready (pop_ready),
        .o_rd_valid  (rd_valid),
        .o_rd_data   (rd_data)
    );

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    // free running clock
    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset low for a few cycles, released on a falling edge
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    import rv_pkg::*;

    localparam int PERIOD_NS        = 100;
    localparam int RESET_CYCLES     = 5;
    localparam int CYCLES_PER_ENTRY = 40;

    // rv32i major opcodes
    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;
    // funct3 field values
    localparam logic [2:0] FN_ADD  = 3'b000;
    localparam logic [2:0] FN_SLL  = 3'b001;
    localparam logic [2:0] FN_SLT  = 3'b010;
    localparam logic [2:0] FN_SLTU = 3'b011;
    localparam logic [2:0] FN_XOR  = 3'b100;
    localparam logic [2:0] FN_SR   = 3'b101;
    localparam logic [2:0] FN_OR   = 3'b110;
    localparam logic [2:0] FN_AND  = 3'b111;
    // funct7 codes where alt picks sub and sra
    localparam logic [6:0] FN7_BASE = 7'b0000000;
    localparam logic [6:0] FN7_ALT  = 7'b0100000;

    // one apb access with its expected response
    typedef struct packed {
        logic                  is_read;
        logic [APB_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       wdata;
        logic [XLEN-1:0]       exp_rdata;
        logic                  exp_err;
    } entry_t;

    logic                  clk;
    logic                  rst_n;
    logic                  i_psel;
    logic                  i_penable;
    logic                  i_pwrite;
    logic [APB_ADDR_W-1:0] i_paddr;
    logic [XLEN-1:0]       i_pwdata;
    logic [XLEN-1:0]       o_prdata;
    logic                  o_pready;
    logic                  o_pslverr;

    entry_t entries [$];
    int     num_entries = 0;

    tb_clock #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .clk   (clk),
        .rst_n (rst_n)
    );

    rv_core_top #(
        .FIFO_DEPTH (4)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr)
    );

    //////////////////////////////////////////////////
    // instruction encoding
    //////////////////////////////////////////////////
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_REG};
    endfunction

    // imm is the raw 12-bit field where srai carries its alt bit
    function automatic logic [31:0] i_type(input logic [2:0] f3, input int rd,
                                           input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), OPC_IMM};
    endfunction

    //////////////////////////////////////////////////
    // table entries
    //////////////////////////////////////////////////
    task automatic append_entry(input logic is_read, input logic [APB_ADDR_W-1:0] addr,
                                input logic [XLEN-1:0] wdata, input logic [XLEN-1:0] exp_rdata,
                                input logic exp_err);
        entry_t e;
        e = {is_read, addr, wdata, exp_rdata, exp_err};
        entries.push_back(e);
    endtask

    task automatic write_instr(input logic [31:0] word);
        append_entry(1'b0, INSTR_OFFSET, word, '0, 1'b0);
    endtask

    task automatic check_reg(input int idx, input logic [XLEN-1:0] value);
        append_entry(1'b1, APB_ADDR_W'(idx * 4), '0, value, 1'b0);
    endtask

    task automatic reject_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] word);
        append_entry(1'b0, addr, word, '0, 1'b1);
    endtask

    task automatic reject_read(input logic [APB_ADDR_W-1:0] addr);
        append_entry(1'b1, addr, '0, '0, 1'b1);
    endtask

    task automatic build_table;
        // registers clear after reset
        check_reg(1, 32'h0000_0000);
        check_reg(17, 32'h0000_0000);
        check_reg(31, 32'h0000_0000);
        // dependent addi chain adding 5 then 3 then -10
        write_instr(i_type(FN_ADD, 1, 0, 5));
        check_reg(1, 32'h0000_0005);
        write_instr(i_type(FN_ADD, 1, 1, 3));
        write_instr(i_type(FN_ADD, 1, 1, -10));
        check_reg(1, 32'hffff_fffe);
        write_instr(i_type(FN_ADD, 2, 1, 7));
        check_reg(2, 32'h0000_0005);
        // operands x3 = -8, x4 = 3, x5 = 0x7ff
        write_instr(i_type(FN_ADD, 3, 0, -8));
        write_instr(i_type(FN_ADD, 4, 0, 3));
        write_instr(i_type(FN_ADD, 5, 0, 2047));
        // r-type group
        write_instr(r_type(FN7_BASE, FN_ADD, 6, 3, 4));
        check_reg(6, 32'hffff_fffb);
        write_instr(r_type(FN7_ALT, FN_ADD, 7, 4, 3));
        check_reg(7, 32'h0000_000b);
        write_instr(r_type(FN7_BASE, FN_SLL, 8, 3, 4));
        check_reg(8, 32'hffff_ffc0);
        write_instr(r_type(FN7_BASE, FN_SLT, 9, 3, 4));
        check_reg(9, 32'h0000_0001);
        write_instr(r_type(FN7_BASE, FN_SLTU, 10, 3, 4));
        check_reg(10, 32'h0000_0000);
        write_instr(r_type(FN7_BASE, FN_SLTU, 26, 4, 3));
        check_reg(26, 32'h0000_0001);
        write_instr(r_type(FN7_BASE, FN_XOR, 11, 3, 5));
        check_reg(11, 32'hffff_f807);
        write_instr(r_type(FN7_BASE, FN_SR, 12, 3, 4));
        check_reg(12, 32'h1fff_ffff);
        write_instr(r_type(FN7_ALT, FN_SR, 13, 3, 4));
        check_reg(13, 32'hffff_ffff);
        write_instr(r_type(FN7_BASE, FN_OR, 14, 3, 4));
        check_reg(14, 32'hffff_fffb);
        write_instr(r_type(FN7_BASE, FN_AND, 15, 3, 5));
        check_reg(15, 32'h0000_07f8);
        // shift amount is rs2 mod 32 which gives 31 here
        write_instr(r_type(FN7_BASE, FN_SLL, 27, 4, 5));
        check_reg(27, 32'h8000_0000);
        // i-type group
        write_instr(i_type(FN_SLT, 16, 3, -7));
        check_reg(16, 32'h0000_0001);
        write_instr(i_type(FN_SLTU, 17, 4, -1));
        check_reg(17, 32'h0000_0001);
        write_instr(i_type(FN_XOR, 18, 3, -1));
        check_reg(18, 32'h0000_0007);
        write_instr(i_type(FN_OR, 19, 4, 12'h700));
        check_reg(19, 32'h0000_0703);
        write_instr(i_type(FN_AND, 20, 3, 12'h0f0));
        check_reg(20, 32'h0000_00f0);
        write_instr(i_type(FN_SLL, 21, 4, 31));
        check_reg(21, 32'h8000_0000);
        write_instr(i_type(FN_SR, 22, 3, 28));
        check_reg(22, 32'h0000_000f);
        write_instr(i_type(FN_SR, 23, 3, 12'h402));
        check_reg(23, 32'hffff_fffe);
        write_instr(i_type(FN_ADD, 24, 4, -2048));
        check_reg(24, 32'hffff_f803);
        // upper imm bits match the sub funct7 yet addi still adds
        write_instr(i_type(FN_ADD, 25, 4, 12'h400));
        check_reg(25, 32'h0000_0403);
        // x0 stays zero
        write_instr(i_type(FN_ADD, 0, 0, 100));
        check_reg(0, 32'h0000_0000);
        write_instr(i_type(FN_ADD, 28, 0, 9));
        check_reg(28, 32'h0000_0009);
        write_instr(r_type(FN7_BASE, FN_ADD, 29, 0, 4));
        check_reg(29, 32'h0000_0003);
        // error responses leave state alone
        reject_write(8'h00, 32'h0000_0003);
        reject_write(8'h04, i_type(FN_ADD, 4, 0, 99));
        reject_write(8'h00, r_type(7'b0000001, FN_ADD, 4, 3, 3));
        check_reg(4, 32'h0000_0003);
        reject_read(8'h06);
        reject_read(8'h80);
        check_reg(3, 32'hffff_fff8);
        // burst longer than the fifo
        write_instr(i_type(FN_ADD, 30, 0, 1));
        for (int k = 0; k < 6; k++)
            write_instr(i_type(FN_ADD, 30, 30, 1));
        check_reg(30, 32'h0000_0007);
    endtask

    //////////////////////////////////////////////////
    // apb master side
    //////////////////////////////////////////////////
    // setup, access, then hold until pready on a rising edge
    task automatic apb_transfer(input entry_t e, output logic [XLEN-1:0] rdata,
                                output logic err);
        @(negedge clk);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = ~e.is_read;
        i_paddr   = e.addr;
        i_pwdata  = e.wdata;
        @(negedge clk);
        i_penable = 1'b1;
        @(posedge clk);
        while (!o_pready)
            @(posedge clk);
        rdata = o_prdata;
        err   = o_pslverr;
        @(negedge clk);
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic report_failure(input string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "check failed");
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial
    begin
        entry_t          e;
        logic [XLEN-1:0] rdata;
        logic            err;

        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        build_table();
        num_entries = entries.size();
        wait (rst_n === 1'b1);
        for (int i = 0; i < num_entries; i++)
        begin
            e = entries[i];
            apb_transfer(e, rdata, err);
            assert (err == e.exp_err)
            else
                report_failure($sformatf("entry %0d addr 0x%02h pslverr %0b, expected %0b",
                                         i, e.addr, err, e.exp_err));
            // data only matters on a good read
            if (e.is_read && !e.exp_err)
            begin
                assert (rdata == e.exp_rdata)
                else
                    report_failure($sformatf("entry %0d x%0d read 0x%08h, expected 0x%08h",
                                             i, e.addr >> 2, rdata, e.exp_rdata));
            end
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

    // watchdog sized from the table
    initial
    begin
        wait (num_entries > 0);
        repeat (RESET_CYCLES + num_entries * CYCLES_PER_ENTRY) @(posedge clk);
        $display("timeout: APB transfers did not finish within %0d cycles",
                 RESET_CYCLES + num_entries * CYCLES_PER_ENTRY);
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// ==== compile.f ====
source/rv_pkg.sv
source/rv_alu.sv
source/rv_regfile.sv
source/rv_execute.sv
source/uop_fifo.sv
source/rv_decoder.sv
source/rv_core_top.sv
bench/tb_clock.sv
bench/tb_rv_core.sv

// ==== Makefile ====
TOP  := tb_rv_core
SRCS := $(wildcard source/*.sv bench/*.sv)

.PHONY: all run clean

all: obj_dir/V$(TOP)

obj_dir/V$(TOP): compile.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP) -f compile.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
